//--- cu_pkg.sv
`default_nettype none

package cu_pkg;

	// field widths
	localparam int ADDR_BITS   = 64;
	localparam int DATA_BITS   = 64;
	localparam int CU_ID_BITS  = 8;
	localparam int VERTEX_BITS = 32;
	localparam int EDGE_BITS   = 32;

	// the configuration word is a single 64-bit field
	// any nonzero value arms the unit
	localparam int CONFIG_BITS = 64;

	typedef logic [ADDR_BITS-1:0]   addr_t;
	typedef logic [DATA_BITS-1:0]   data_t;
	typedef logic [CU_ID_BITS-1:0]  cu_id_t;
	typedef logic [VERTEX_BITS-1:0] vertex_count_t;
	typedef logic [EDGE_BITS-1:0]   edge_count_t;
	typedef logic [CONFIG_BITS-1:0] config_word_t;

	// tag owned by the vertex job side
	// every other tag routes to the algorithm side
	localparam cu_id_t VERTEX_CONTROL_ID = 8'd0;

	// read command sources: 0 vertex job, 1 algorithm
	localparam int NUM_READ_SOURCES = 2;

endpackage

`default_nettype wire

//--- cu_reset_tree.sv
`timescale 1ns/1ps
`default_nettype none

module cu_reset_tree (
	input  wire logic clock,
	input  wire logic rstn,
	output logic      rstn_core,
	output logic      rstn_input,
	output logic      rstn_output
);

	logic rstn_sync;

	// first stage, shared by all domains
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rstn_sync <= 1'b0;
		end else begin
			rstn_sync <= 1'b1;
		end
	end

	// second stage replicated so each domain gets its own driver
	always_ff @(posedge clock or negedge rstn_sync) begin
		if (!rstn_sync) begin
			rstn_core   <= 1'b0;
			rstn_input  <= 1'b0;
			rstn_output <= 1'b0;
		end else begin
			rstn_core   <= 1'b1;
			rstn_input  <= 1'b1;
			rstn_output <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- cu_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cu_config_regs (
	input  wire logic                  clock,
	input  wire logic                  rstn_input,
	input  wire logic                  enabled_in,
	input  wire logic                  job_valid,
	input  wire cu_pkg::vertex_count_t job_num_vertices,
	input  wire cu_pkg::edge_count_t   job_num_edges,
	input  wire cu_pkg::config_word_t  config_in,
	output logic                       enabled,
	output logic                       cu_ready,
	output cu_pkg::vertex_count_t      num_vertices,
	output cu_pkg::edge_count_t        num_edges,
	output cu_pkg::config_word_t       cu_status
);

	import cu_pkg::*;

	logic         job_latched;
	config_word_t config_word;

	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			enabled     <= 1'b0;
			job_latched <= 1'b0;
			config_word <= '0;
			cu_status   <= '0;
		end else begin
			enabled <= enabled_in;
			if (enabled) begin
				if (job_valid) begin
					job_latched <= 1'b1;
				end
				// an all zero word leaves the last setting in place
				if (|config_in) begin
					config_word <= config_in;
				end
				cu_status <= config_word;
			end
		end
	end

	// job descriptor
	always_ff @(posedge clock) begin
		if (enabled && job_valid) begin
			num_vertices <= job_num_vertices;
			num_edges    <= job_num_edges;
		end
	end

	assign cu_ready = (|config_word) && job_latched;

endmodule

`default_nettype wire

//--- cu_response_router.sv
`timescale 1ns/1ps
`default_nettype none

module cu_response_router (
	input  wire logic           clock,
	input  wire logic           rstn_core,
	input  wire logic           rstn_input,
	input  wire logic           enabled,
	input  wire logic           response_valid,
	input  wire cu_pkg::cu_id_t response_cu_id,
	input  wire cu_pkg::data_t  response_payload,
	input  wire logic           data_valid,
	input  wire cu_pkg::cu_id_t data_cu_id,
	input  wire cu_pkg::data_t  data_payload,
	output logic                vertex_response_valid,
	output cu_pkg::data_t       vertex_response_payload,
	output logic                algorithm_response_valid,
	output cu_pkg::data_t       algorithm_response_payload,
	output logic                vertex_data_valid,
	output cu_pkg::data_t       vertex_data_payload,
	output logic                algorithm_data_valid,
	output cu_pkg::data_t       algorithm_data_payload
);

	import cu_pkg::*;

	// lane 0 is the read response, lane 1 the read data
	localparam int NUM_LANES = 2;

	logic   lane_valid      [NUM_LANES];
	cu_id_t lane_cu_id      [NUM_LANES];
	data_t  lane_payload    [NUM_LANES];
	logic   latched_valid   [NUM_LANES];
	cu_id_t latched_cu_id   [NUM_LANES];
	data_t  latched_payload [NUM_LANES];
	logic   vertex_valid    [NUM_LANES];
	logic   algorithm_valid [NUM_LANES];
	data_t  steered_payload [NUM_LANES];

	assign lane_valid[0]   = response_valid;
	assign lane_cu_id[0]   = response_cu_id;
	assign lane_payload[0] = response_payload;
	assign lane_valid[1]   = data_valid;
	assign lane_cu_id[1]   = data_cu_id;
	assign lane_payload[1] = data_payload;

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane

		////////////////////////////////////////////////
		// stage 1 latches the input
		////////////////////////////////////////////////

		always_ff @(posedge clock or negedge rstn_input) begin
			if (!rstn_input) begin
				latched_valid[i] <= 1'b0;
			end else begin
				latched_valid[i] <= enabled && lane_valid[i];
			end
		end

		always_ff @(posedge clock) begin
			latched_cu_id[i]   <= lane_cu_id[i];
			latched_payload[i] <= lane_payload[i];
		end

		////////////////////////////////////////////////
		// stage 2 steers by tag
		////////////////////////////////////////////////

		always_ff @(posedge clock or negedge rstn_core) begin
			if (!rstn_core) begin
				vertex_valid[i]    <= 1'b0;
				algorithm_valid[i] <= 1'b0;
			end else if (enabled && latched_valid[i]) begin
				vertex_valid[i]    <= (latched_cu_id[i] == VERTEX_CONTROL_ID);
				algorithm_valid[i] <= (latched_cu_id[i] != VERTEX_CONTROL_ID);
			end else begin
				vertex_valid[i]    <= 1'b0;
				algorithm_valid[i] <= 1'b0;
			end
		end

		// both sides see the same payload and only the valid picks the owner
		always_ff @(posedge clock) begin
			steered_payload[i] <= latched_payload[i];
		end

		// each side only carries items whose tag it owns, so never both at once
		a_vertex_owned: assert property (@(posedge clock) disable iff (!rstn_core)
			vertex_valid[i] |->
				$past(lane_valid[i] && (lane_cu_id[i] == VERTEX_CONTROL_ID), 2));
		a_algorithm_owned: assert property (@(posedge clock) disable iff (!rstn_core)
			algorithm_valid[i] |->
				$past(lane_valid[i] && (lane_cu_id[i] != VERTEX_CONTROL_ID), 2));
	end

	assign vertex_response_valid      = vertex_valid[0];
	assign vertex_response_payload    = steered_payload[0];
	assign algorithm_response_valid   = algorithm_valid[0];
	assign algorithm_response_payload = steered_payload[0];
	assign vertex_data_valid          = vertex_valid[1];
	assign vertex_data_payload        = steered_payload[1];
	assign algorithm_data_valid       = algorithm_valid[1];
	assign algorithm_data_payload     = steered_payload[1];

endmodule

`default_nettype wire

//--- cu_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cu_read_arbiter #(
	parameter int NUM_REQUESTS = 2
) (
	input  wire logic                    clock,
	input  wire logic                    rstn_core,
	input  wire logic                    enabled,
	input  wire logic [NUM_REQUESTS-1:0] requests,
	input  wire logic [NUM_REQUESTS-1:0] command_valid,
	input  wire cu_pkg::addr_t           command_address [NUM_REQUESTS],
	input  wire cu_pkg::cu_id_t          command_cu_id   [NUM_REQUESTS],
	output logic [NUM_REQUESTS-1:0]      grant,
	output logic                         grant_valid,
	output cu_pkg::addr_t                grant_address,
	output cu_pkg::cu_id_t               grant_cu_id
);

	localparam int IDX_BITS = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [IDX_BITS-1:0]     last_grant;
	logic [IDX_BITS-1:0]     select;
	logic [NUM_REQUESTS-1:0] next_grant;

	// walk from the farthest source back to the one just past last_grant
	// so the nearest requester after the last grant wins
	always_comb begin : search
		int idx;
		next_grant = '0;
		select     = last_grant;
		for (int k = NUM_REQUESTS; k >= 1; k--) begin
			idx = (int'(last_grant) + k) % NUM_REQUESTS;
			if (requests[idx]) begin
				next_grant      = '0;
				next_grant[idx] = 1'b1;
				select          = IDX_BITS'(idx);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn_core) begin
		if (!rstn_core) begin
			grant       <= '0;
			grant_valid <= 1'b0;
			// first pass starts at source 0
			last_grant  <= IDX_BITS'(NUM_REQUESTS - 1);
		end else if (enabled) begin
			grant       <= next_grant;
			grant_valid <= |(next_grant & command_valid);
			if (|next_grant) begin
				last_grant <= select;
			end
		end else begin
			grant       <= '0;
			grant_valid <= 1'b0;
		end
	end

	// selected command travels with the grant
	always_ff @(posedge clock) begin
		grant_address <= command_address[select];
		grant_cu_id   <= command_cu_id[select];
	end

	// one-hot or zero, and a source wins twice in a row only when nobody else asked
	a_grant_fair: assert property (@(posedge clock) disable iff (!rstn_core)
		$onehot0(grant) &&
		(((grant & $past(grant)) == '0) || (($past(requests) & ~$past(grant)) == '0)));

endmodule

`default_nettype wire

//--- cu_done_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module cu_done_tracker (
	input  wire logic                  clock,
	input  wire logic                  rstn_core,
	input  wire logic                  enabled,
	input  wire logic                  cu_ready,
	input  wire cu_pkg::vertex_count_t num_vertices,
	input  wire cu_pkg::edge_count_t   num_edges,
	input  wire cu_pkg::vertex_count_t vertex_done,
	input  wire cu_pkg::vertex_count_t vertex_filtered,
	input  wire cu_pkg::edge_count_t   edge_done,
	output logic                       cu_done,
	output cu_pkg::vertex_count_t      return_vertices,
	output cu_pkg::edge_count_t        return_edges
);

	import cu_pkg::*;

	vertex_count_t vertex_total;
	edge_count_t   edge_total;
	logic          totals_match;

	// filtered vertices count as processed
	always_ff @(posedge clock or negedge rstn_core) begin
		if (!rstn_core) begin
			vertex_total <= '0;
			edge_total   <= '0;
		end else if (enabled) begin
			vertex_total <= vertex_done + vertex_filtered;
			edge_total   <= edge_done;
		end
	end

	////////////////////////////////////////////////
	// compare against the job, then report
	////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_core) begin
		if (!rstn_core) begin
			totals_match    <= 1'b0;
			cu_done         <= 1'b0;
			return_vertices <= '0;
			return_edges    <= '0;
		end else if (enabled) begin
			totals_match    <= cu_ready && (vertex_total == num_vertices) &&
				(edge_total == num_edges);
			cu_done         <= totals_match;
			return_vertices <= vertex_total;
			return_edges    <= edge_total;
		end
	end

endmodule

`default_nettype wire

//--- cu_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cu_output_stage (
	input  wire logic           clock,
	input  wire logic           rstn_output,
	input  wire logic           enabled,
	input  wire logic           cu_ready,
	input  wire logic           write_command_valid,
	input  wire cu_pkg::addr_t  write_command_address,
	input  wire logic           write_data_valid,
	input  wire cu_pkg::data_t  write_data_payload,
	input  wire logic           arbiter_command_valid,
	input  wire cu_pkg::addr_t  arbiter_command_address,
	input  wire cu_pkg::cu_id_t arbiter_command_cu_id,
	input  wire logic           write_request,
	input  wire logic           write_almost_full,
	output logic                mem_write_command_valid,
	output cu_pkg::addr_t       mem_write_command_address,
	output logic                mem_write_data_valid,
	output cu_pkg::data_t       mem_write_data_payload,
	output logic                mem_read_command_valid,
	output cu_pkg::addr_t       mem_read_command_address,
	output cu_pkg::cu_id_t      mem_read_command_cu_id,
	output logic                write_grant
);

	logic issue;
	logic write_request_q;
	logic almost_full_q;

	// commands only leave once the unit is configured
	assign issue = enabled && cu_ready;

	always_ff @(posedge clock or negedge rstn_output) begin
		if (!rstn_output) begin
			mem_write_command_valid <= 1'b0;
			mem_write_data_valid    <= 1'b0;
			mem_read_command_valid  <= 1'b0;
			write_request_q         <= 1'b0;
			almost_full_q           <= 1'b0;
		end else begin
			mem_write_command_valid <= issue && write_command_valid;
			mem_write_data_valid    <= issue && write_data_valid;
			mem_read_command_valid  <= issue && arbiter_command_valid;
			write_request_q         <= issue && write_request;
			almost_full_q           <= write_almost_full;
		end
	end

	always_ff @(posedge clock) begin
		mem_write_command_address <= write_command_address;
		mem_write_data_payload    <= write_data_payload;
		mem_read_command_address  <= arbiter_command_address;
		mem_read_command_cu_id    <= arbiter_command_cu_id;
	end

	// back-pressure from the write buffer holds the grant low
	assign write_grant = write_request_q && !almost_full_q;

endmodule

`default_nettype wire

//--- cu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cu_control #(
	parameter int NUM_REQUESTS = cu_pkg::NUM_READ_SOURCES
) (
	input  wire logic                    clock,
	input  wire logic                    rstn,
	input  wire logic                    enabled_in,
	input  wire logic                    job_valid,
	input  wire cu_pkg::vertex_count_t   job_num_vertices,
	input  wire cu_pkg::edge_count_t     job_num_edges,
	input  wire cu_pkg::config_word_t    config_in,
	output logic                         cu_ready,
	output cu_pkg::config_word_t         cu_status,
	input  wire logic                    response_valid,
	input  wire cu_pkg::cu_id_t          response_cu_id,
	input  wire cu_pkg::data_t           response_payload,
	input  wire logic                    data_valid,
	input  wire cu_pkg::cu_id_t          data_cu_id,
	input  wire cu_pkg::data_t           data_payload,
	output logic                         vertex_response_valid,
	output cu_pkg::data_t                vertex_response_payload,
	output logic                         algorithm_response_valid,
	output cu_pkg::data_t                algorithm_response_payload,
	output logic                         vertex_data_valid,
	output cu_pkg::data_t                vertex_data_payload,
	output logic                         algorithm_data_valid,
	output cu_pkg::data_t                algorithm_data_payload,
	input  wire logic [NUM_REQUESTS-1:0] read_request,
	input  wire logic [NUM_REQUESTS-1:0] read_command_valid,
	input  wire cu_pkg::addr_t           read_command_address [NUM_REQUESTS],
	input  wire cu_pkg::cu_id_t          read_command_cu_id   [NUM_REQUESTS],
	output logic [NUM_REQUESTS-1:0]      read_grant,
	input  wire logic                    write_command_valid,
	input  wire cu_pkg::addr_t           write_command_address,
	input  wire logic                    write_data_valid,
	input  wire cu_pkg::data_t           write_data_payload,
	input  wire logic                    write_request,
	input  wire logic                    write_almost_full,
	output logic                         write_grant,
	output logic                         mem_write_command_valid,
	output cu_pkg::addr_t                mem_write_command_address,
	output logic                         mem_write_data_valid,
	output cu_pkg::data_t                mem_write_data_payload,
	output logic                         mem_read_command_valid,
	output cu_pkg::addr_t                mem_read_command_address,
	output cu_pkg::cu_id_t               mem_read_command_cu_id,
	input  wire cu_pkg::vertex_count_t   vertex_done,
	input  wire cu_pkg::vertex_count_t   vertex_filtered,
	input  wire cu_pkg::edge_count_t     edge_done,
	output logic                         cu_done,
	output cu_pkg::vertex_count_t        return_vertices,
	output cu_pkg::edge_count_t          return_edges
);

	import cu_pkg::*;

	logic          rstn_core;
	logic          rstn_input;
	logic          rstn_output;
	logic          enabled;
	vertex_count_t num_vertices;
	edge_count_t   num_edges;
	logic          arbiter_command_valid;
	addr_t         arbiter_command_address;
	cu_id_t        arbiter_command_cu_id;

	//////////////////////////////////////////////////
	// reset and configuration
	//////////////////////////////////////////////////

	cu_reset_tree u_reset_tree (.*);

	cu_config_regs u_config_regs (.*);

	//////////////////////////////////////////////////
	// inbound steering and read arbitration
	//////////////////////////////////////////////////

	cu_response_router u_response_router (.*);

	// source 0 is the vertex job side
	cu_read_arbiter #(
		.NUM_REQUESTS(NUM_REQUESTS)
	) u_read_arbiter (
		.clock          (clock                  ),
		.rstn_core      (rstn_core              ),
		.enabled        (enabled                ),
		.requests       (read_request           ),
		.command_valid  (read_command_valid     ),
		.command_address(read_command_address   ),
		.command_cu_id  (read_command_cu_id     ),
		.grant          (read_grant             ),
		.grant_valid    (arbiter_command_valid  ),
		.grant_address  (arbiter_command_address),
		.grant_cu_id    (arbiter_command_cu_id  )
	);

	//////////////////////////////////////////////////
	// completion and outbound traffic
	//////////////////////////////////////////////////

	cu_done_tracker u_done_tracker (.*);

	cu_output_stage u_output_stage (.*);

endmodule

`default_nettype wire

//--- tb_cu_checks.svh
`ifndef TB_CU_CHECKS_SVH
`define TB_CU_CHECKS_SVH

// vertex total of a job: processed plus filtered
function automatic vertex_count_t expected_vertex_total(input vertex_count_t done_count,
	input vertex_count_t filtered_count);
	return done_count + filtered_count;
endfunction

// tag 0 is owned by the vertex job side, all others by the algorithm side
function automatic bit goes_to_vertex(input cu_id_t tag);
	return tag == 8'd0;
endfunction

task automatic check_flag(input string check, input logic expected, input logic actual);
	if (actual !== expected) begin
		report_mismatch(check, $sformatf("%b", expected), $sformatf("%b", actual));
	end
endtask

task automatic check_data(input string check, input data_t expected, input data_t actual);
	if (actual !== expected) begin
		report_mismatch(check, $sformatf("%h", expected), $sformatf("%h", actual));
	end
endtask

task automatic check_addr(input string check, input addr_t expected, input addr_t actual);
	if (actual !== expected) begin
		report_mismatch(check, $sformatf("%h", expected), $sformatf("%h", actual));
	end
endtask

task automatic check_id(input string check, input cu_id_t expected, input cu_id_t actual);
	if (actual !== expected) begin
		report_mismatch(check, $sformatf("%h", expected), $sformatf("%h", actual));
	end
endtask

task automatic check_count(input string check, input vertex_count_t expected,
	input vertex_count_t actual);
	if (actual !== expected) begin
		report_mismatch(check, $sformatf("%0d", expected), $sformatf("%0d", actual));
	end
endtask

task automatic check_edges(input string check, input edge_count_t expected,
	input edge_count_t actual);
	if (actual !== expected) begin
		report_mismatch(check, $sformatf("%0d", expected), $sformatf("%0d", actual));
	end
endtask

task automatic check_status(input string check, input config_word_t expected,
	input config_word_t actual);
	if (actual !== expected) begin
		report_mismatch(check, $sformatf("%h", expected), $sformatf("%h", actual));
	end
endtask

// one routed lane: valids on both sides, payload on the side that owns it
task automatic check_lane(input string lane, input logic exp_vertex, input logic exp_algorithm,
	input data_t exp_payload, input logic act_vertex, input logic act_algorithm,
	input data_t act_vertex_payload, input data_t act_algorithm_payload);
	check_flag({lane, " vertex valid"}, exp_vertex, act_vertex);
	check_flag({lane, " algorithm valid"}, exp_algorithm, act_algorithm);
	if (exp_vertex) begin
		check_data({lane, " vertex payload"}, exp_payload, act_vertex_payload);
	end
	if (exp_algorithm) begin
		check_data({lane, " algorithm payload"}, exp_payload, act_algorithm_payload);
	end
endtask

`endif

//--- tb_cu_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cu_control;

	import cu_pkg::*;

	localparam int N_ROUTE = 48;
	localparam int N_ARB   = 8;
	localparam int N_ITEMS = N_ROUTE + N_ARB + 16;
	localparam int ITEM_NS = 40;
	localparam int RING    = 16;

	logic                        clock;
	logic                        rstn;
	logic                        enabled_in;
	logic                        job_valid;
	vertex_count_t               job_num_vertices;
	edge_count_t                 job_num_edges;
	config_word_t                config_in;
	logic                        cu_ready;
	config_word_t                cu_status;
	logic                        response_valid;
	cu_id_t                      response_cu_id;
	data_t                       response_payload;
	logic                        data_valid;
	cu_id_t                      data_cu_id;
	data_t                       data_payload;
	logic                        vertex_response_valid;
	logic                        algorithm_response_valid;
	logic                        vertex_data_valid;
	logic                        algorithm_data_valid;
	data_t                       vertex_response_payload;
	data_t                       algorithm_response_payload;
	data_t                       vertex_data_payload;
	data_t                       algorithm_data_payload;
	logic [NUM_READ_SOURCES-1:0] read_request;
	logic [NUM_READ_SOURCES-1:0] read_command_valid;
	addr_t                       read_command_address [NUM_READ_SOURCES];
	cu_id_t                      read_command_cu_id   [NUM_READ_SOURCES];
	logic [NUM_READ_SOURCES-1:0] read_grant;
	logic                        write_command_valid;
	addr_t                       write_command_address;
	logic                        write_data_valid;
	data_t                       write_data_payload;
	logic                        write_request;
	logic                        write_almost_full;
	logic                        write_grant;
	logic                        mem_write_command_valid;
	addr_t                       mem_write_command_address;
	logic                        mem_write_data_valid;
	data_t                       mem_write_data_payload;
	logic                        mem_read_command_valid;
	addr_t                       mem_read_command_address;
	cu_id_t                      mem_read_command_cu_id;
	vertex_count_t               vertex_done;
	vertex_count_t               vertex_filtered;
	edge_count_t                 edge_done;
	logic                        cu_done;
	vertex_count_t               return_vertices;
	edge_count_t                 return_edges;

	int          seed;
	int unsigned cycle = 0;
	int unsigned check_slot;
	int          error_count;
	bit          route_check_on;
	string       current_test;

	// expected routing results, indexed by the cycle they are due in
	logic  exp_resp_vertex    [RING];
	logic  exp_resp_algorithm [RING];
	data_t exp_resp_payload   [RING];
	logic  exp_data_vertex    [RING];
	logic  exp_data_algorithm [RING];
	data_t exp_data_payload   [RING];

	cu_control #(
		.NUM_REQUESTS(NUM_READ_SOURCES)
	) u_dut (.*);

	initial begin
		clock = 1'b0;
	end

	always begin
		#2;
		clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic fail_now(input string what);
		error_count++;
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string check, input string expected,
		input string actual);
		fail_now($sformatf("ERR %s %s: expected %s, actual %s", current_test, check,
			expected, actual));
	endtask

	`include "tb_cu_checks.svh"

	function automatic data_t random_word();
		return {$random(seed), $random(seed)};
	endfunction

	// half of all tags land on the vertex side
	function automatic cu_id_t random_tag();
		if ($random(seed) & 1) begin
			return 8'd0;
		end
		return cu_id_t'($random(seed));
	endfunction

	task automatic idle_inputs();
		enabled_in            = 1'b0;
		job_valid             = 1'b0;
		job_num_vertices      = '0;
		job_num_edges         = '0;
		config_in             = '0;
		response_valid        = 1'b0;
		response_cu_id        = '0;
		response_payload      = '0;
		data_valid            = 1'b0;
		data_cu_id            = '0;
		data_payload          = '0;
		read_request          = '0;
		read_command_valid    = '0;
		write_command_valid   = 1'b0;
		write_command_address = '0;
		write_data_valid      = 1'b0;
		write_data_payload    = '0;
		write_request         = 1'b0;
		write_almost_full     = 1'b0;
		vertex_done           = '0;
		vertex_filtered       = '0;
		edge_done             = '0;
		for (int i = 0; i < NUM_READ_SOURCES; i++) begin
			read_command_address[i] = '0;
			read_command_cu_id[i]   = '0;
		end
		for (int i = 0; i < RING; i++) begin
			exp_resp_vertex[i]    = 1'b0;
			exp_resp_algorithm[i] = 1'b0;
			exp_resp_payload[i]   = '0;
			exp_data_vertex[i]    = 1'b0;
			exp_data_algorithm[i] = 1'b0;
			exp_data_payload[i]   = '0;
		end
	endtask

	task automatic check_idle();
		check_flag("vertex response valid", 1'b0, vertex_response_valid);
		check_flag("algorithm response valid", 1'b0, algorithm_response_valid);
		check_flag("vertex data valid", 1'b0, vertex_data_valid);
		check_flag("algorithm data valid", 1'b0, algorithm_data_valid);
		check_flag("memory write command valid", 1'b0, mem_write_command_valid);
		check_flag("memory write data valid", 1'b0, mem_write_data_valid);
		check_flag("memory read command valid", 1'b0, mem_read_command_valid);
		check_flag("read grant", 1'b0, |read_grant);
		check_flag("write grant", 1'b0, write_grant);
		check_flag("cu_done", 1'b0, cu_done);
		check_flag("cu_ready", 1'b0, cu_ready);
	endtask

	// item sampled on the next edge shows up two edges later
	task automatic drive_route_item();
		int unsigned due;
		due              = (cycle + 2) % RING;
		response_valid   = 1'($random(seed));
		response_cu_id   = random_tag();
		response_payload = random_word();
		data_valid       = 1'($random(seed));
		data_cu_id       = random_tag();
		data_payload     = random_word();
		exp_resp_vertex[due]    = response_valid && goes_to_vertex(response_cu_id);
		exp_resp_algorithm[due] = response_valid && !goes_to_vertex(response_cu_id);
		exp_resp_payload[due]   = response_payload;
		exp_data_vertex[due]    = data_valid && goes_to_vertex(data_cu_id);
		exp_data_algorithm[due] = data_valid && !goes_to_vertex(data_cu_id);
		exp_data_payload[due]   = data_payload;
	endtask

	task automatic wait_status(input config_word_t expected);
		int waited;
		waited = 0;
		while (cu_status !== expected && waited < 8) begin
			@(negedge clock);
			waited++;
		end
		if (cu_status !== expected) begin
			fail_now("cu_status never took the new configuration word");
		end
	endtask

	task automatic wait_grant();
		int waited;
		waited = 0;
		while (read_grant == '0 && waited < 4) begin
			@(negedge clock);
			waited++;
		end
		if (read_grant == '0) begin
			fail_now("the read arbiter never granted a pending request");
		end
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		while (cu_done !== 1'b1 && waited < 4) begin
			@(negedge clock);
			waited++;
		end
		if (cu_done !== 1'b1) begin
			fail_now("cu_done did not rise within 4 cycles of the counts matching");
		end
	endtask

	task automatic hold_not_done(input vertex_count_t done_count,
		input vertex_count_t filtered_count, input edge_count_t edges);
		vertex_done     = done_count;
		vertex_filtered = filtered_count;
		edge_done       = edges;
		repeat (4) begin
			@(negedge clock);
			check_flag("done held low", 1'b0, cu_done);
		end
	endtask

	// routing results are compared here on every cycle
	always @(negedge clock) begin
		if (route_check_on) begin
			check_slot = cycle % RING;
			check_lane("response", exp_resp_vertex[check_slot], exp_resp_algorithm[check_slot],
				exp_resp_payload[check_slot], vertex_response_valid, algorithm_response_valid,
				vertex_response_payload, algorithm_response_payload);
			check_lane("data", exp_data_vertex[check_slot], exp_data_algorithm[check_slot],
				exp_data_payload[check_slot], vertex_data_valid, algorithm_data_valid,
				vertex_data_payload, algorithm_data_payload);
			exp_resp_vertex[check_slot]    = 1'b0;
			exp_resp_algorithm[check_slot] = 1'b0;
			exp_data_vertex[check_slot]    = 1'b0;
			exp_data_algorithm[check_slot] = 1'b0;
		end
	end

	initial begin : watchdog
		#(ITEM_NS * N_ITEMS);
		fail_now("watchdog expired before the tests finished");
	end

	initial begin : run_tests
		logic [NUM_READ_SOURCES-1:0] last_grant;
		int                          src;
		vertex_count_t               job_vertices;
		edge_count_t                 job_edges;
		config_word_t                status_word;
		addr_t                       write_address;
		data_t                       write_word;

		seed           = 32'h8b4a45d4;
		error_count    = 0;
		route_check_on = 1'b0;
		current_test   = "reset";
		idle_inputs();
		rstn = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		repeat (3) @(negedge clock);
		check_idle();
		route_check_on = 1'b1;

		//////////////////////////////////////////////////
		// configuration and job descriptor
		//////////////////////////////////////////////////

		current_test     = "configuration";
		job_vertices     = (vertex_count_t'($random(seed)) & 32'hffff) + 32'd1;
		job_edges        = (edge_count_t'($random(seed)) & 32'hffff) + 32'd1;
		status_word      = random_word() | 64'h1;
		enabled_in       = 1'b1;
		job_valid        = 1'b1;
		job_num_vertices = job_vertices;
		job_num_edges    = job_edges;
		config_in        = status_word;
		repeat (2) @(negedge clock);
		job_valid = 1'b0;
		wait_status(status_word);
		check_flag("cu_ready after setup", 1'b1, cu_ready);
		// zero word must leave the status alone
		config_in = '0;
		repeat (4) begin
			@(negedge clock);
			check_status("zero word ignored", status_word, cu_status);
		end
		status_word = random_word() | 64'h2;
		config_in   = status_word;
		wait_status(status_word);

		//////////////////////////////////////////////////
		// response and data steering
		//////////////////////////////////////////////////

		current_test = "routing";
		repeat (N_ROUTE) begin
			@(negedge clock);
			drive_route_item();
		end
		@(negedge clock);
		response_valid = 1'b0;
		data_valid     = 1'b0;
		repeat (3) @(negedge clock);

		//////////////////////////////////////////////////
		// read arbitration and write back-pressure
		//////////////////////////////////////////////////

		current_test            = "arbitration";
		read_command_address[0] = random_word();
		read_command_address[1] = random_word();
		read_command_cu_id[0]   = 8'd0;
		read_command_cu_id[1]   = random_tag() | 8'd1;
		read_command_valid      = '1;
		read_request            = '1;
		wait_grant();
		last_grant = read_grant;
		repeat (N_ARB) begin
			@(negedge clock);
			src = last_grant[1] ? 1 : 0;
			check_flag("read command valid", 1'b1, mem_read_command_valid);
			check_addr("read command address", read_command_address[src],
				mem_read_command_address);
			check_id("read command tag", read_command_cu_id[src], mem_read_command_cu_id);
			check_flag("grant to source 0", last_grant[1], read_grant[0]);
			check_flag("grant to source 1", last_grant[0], read_grant[1]);
			last_grant = read_grant;
		end
		read_request       = '0;
		read_command_valid = '0;
		repeat (2) @(negedge clock);

		current_test      = "write grant";
		write_request     = 1'b1;
		write_almost_full = 1'b1;
		repeat (4) begin
			@(negedge clock);
			check_flag("grant held by almost full", 1'b0, write_grant);
		end
		write_almost_full = 1'b0;
		@(negedge clock);
		check_flag("grant after almost full drops", 1'b1, write_grant);
		write_request = 1'b0;
		@(negedge clock);

		current_test          = "write path";
		write_address         = random_word();
		write_word            = random_word();
		write_command_valid   = 1'b1;
		write_command_address = write_address;
		write_data_valid      = 1'b1;
		write_data_payload    = write_word;
		@(negedge clock);
		check_flag("memory write command valid", 1'b1, mem_write_command_valid);
		check_addr("memory write command address", write_address, mem_write_command_address);
		check_flag("memory write data valid", 1'b1, mem_write_data_valid);
		check_data("memory write data payload", write_word, mem_write_data_payload);
		write_command_valid = 1'b0;
		write_data_valid    = 1'b0;
		@(negedge clock);
		check_flag("memory write command idle", 1'b0, mem_write_command_valid);
		check_flag("memory write data idle", 1'b0, mem_write_data_valid);

		//////////////////////////////////////////////////
		// completion
		//////////////////////////////////////////////////

		current_test = "done";
		hold_not_done(job_vertices >> 1, '0, job_edges);
		hold_not_done(job_vertices, '0, job_edges - 32'd1);
		vertex_done     = job_vertices >> 1;
		vertex_filtered = job_vertices - (job_vertices >> 1);
		edge_done       = job_edges;
		wait_done();
		check_count("returned vertices", expected_vertex_total(vertex_done, vertex_filtered),
			return_vertices);
		check_edges("returned edges", edge_done, return_edges);

		repeat (2) @(negedge clock);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cu_control.f
+incdir+.
cu_pkg.sv
cu_reset_tree.sv
cu_config_regs.sv
cu_response_router.sv
cu_read_arbiter.sv
cu_done_tracker.sv
cu_output_stage.sv
cu_control.sv
tb_cu_control.sv
